//--- design/gamePkg.sv
package gamePkg;

	// Top-level flow of one round and of the whole game
	typedef enum logic [2:0]
	{
		resetWait,
		launch,
		hold,
		rest,
		over
	} gameState;

	// One decimal digit in BCD
	typedef logic [3:0] bcdDigit;

	// Four BCD digits, thousands in the top nibble
	typedef logic [15:0] bcdScore;

	// Two BCD digits of remaining seconds
	typedef logic [7:0] bcdTime;

	// Active-low segments, bit 0 drives segment a
	typedef logic [6:0] segPattern;

	// Which of the four holes holds the mole
	typedef logic [1:0] moleIndex;

	// One bit per key or per LED
	typedef logic [3:0] keyVector;

endpackage

//--- design/timingPkg.sv
package timingPkg;

	// Cycle count inside one second
	typedef logic [15:0] tickCount;

	// Score where the hold window halves
	localparam gamePkg::bcdScore tierOneScore = 16'h0015;

	// Score where the hold window drops to a quarter
	localparam gamePkg::bcdScore tierTwoScore = 16'h0030;

	// Length of one game in seconds
	localparam gamePkg::bcdTime gameSecondsBcd = 8'h45;

	// Start value of the mole position generator
	localparam logic [7:0] lfsrSeed = 8'd1;

endpackage

//--- design/segmentDecoder.sv
`timescale 1ns/100ps

module segmentDecoder
(
	input  gamePkg::bcdDigit digit,
	output gamePkg::segPattern segments
);

	// Active low, segment g in the top bit
	always_comb
	begin
		case (digit)
			4'd0: segments = 7'b1000000;
			4'd1: segments = 7'b1111001;
			4'd2: segments = 7'b0100100;
			4'd3: segments = 7'b0110000;
			4'd4: segments = 7'b0011001;
			4'd5: segments = 7'b0010010;
			4'd6: segments = 7'b0000010;
			4'd7: segments = 7'b1111000;
			4'd8: segments = 7'b0000000;
			4'd9: segments = 7'b0010000;
			// Not a BCD digit so leave it dark
			default: segments = 7'b1111111;
		endcase
	end

endmodule

//--- design/gameControl.sv
`timescale 1ns/100ps

module gameControl
(
	input  logic clock,
	input  logic reset,
	input  logic gameOver,
	input  logic hit,
	input  logic wrong,
	input  logic expired,
	input  logic keysIdle,
	output logic step,
	output logic holdActive
);

	import gamePkg::*;

	gameState state;
	gameState nextState;

	// State register
	// Running out of time beats every other transition
	always_ff @(posedge clock)
	begin
		if (reset)
			state <= resetWait;
		else if (gameOver)
			state <= over;
		else
			state <= nextState;
	end

	// Next state decode
	always_comb
	begin
		nextState = state;
		case (state)
			// Leave reset on the first free cycle
			resetWait:
				nextState = launch;
			// One cycle to pick a new hole
			launch:
				nextState = hold;
			// Mole is up until judged or timed out
			hold:
				if (hit || wrong || expired)
					nextState = rest;
			// Wait for the player to let go of every key
			rest:
				if (keysIdle)
					nextState = launch;
			// Only reset leaves this state
			over:
				nextState = over;
			default:
				nextState = resetWait;
		endcase
	end

	// Moore outputs to the data modules
	assign step = (state == launch);
	assign holdActive = (state == hold);

endmodule

//--- design/holdTimer.sv
`timescale 1ns/100ps

module holdTimer
#(
	parameter timingPkg::tickCount ticksPerSecond = 16'd64
)
(
	input  logic clock,
	input  logic reset,
	input  logic holdActive,
	input  gamePkg::bcdScore score,
	output logic expired
);

	import timingPkg::*;

	tickCount holdCount;
	tickCount holdLimit;

	// Window length by score tier
	// BCD compares like binary since digits keep their order
	assign holdLimit = (score >= tierTwoScore) ? (ticksPerSecond >> 2) :
		(score >= tierOneScore) ? (ticksPerSecond >> 1) : ticksPerSecond;

	// Cycles spent in the current hold
	always_ff @(posedge clock)
	begin
		if (reset || !holdActive)
			holdCount <= '0;
		else
			holdCount <= holdCount + 1'b1;
	end

	// High on the last cycle of the window
	assign expired = holdActive && (holdCount == holdLimit - 1'b1);

endmodule

//--- design/gameClock.sv
`timescale 1ns/100ps

module gameClock
#(
	parameter timingPkg::tickCount ticksPerSecond = 16'd64
)
(
	input  logic clock,
	input  logic reset,
	output gamePkg::bcdTime timeLeft,
	output logic gameOver
);

	import gamePkg::*;
	import timingPkg::*;

	tickCount prescale;
	logic secondTick;
	bcdDigit timeTens;
	bcdDigit timeOnes;

	// Prescaler runs freely from reset
	always_ff @(posedge clock)
	begin
		if (reset || secondTick)
			prescale <= '0;
		else
			prescale <= prescale + 1'b1;
	end

	// One pulse per second
	assign secondTick = (prescale == ticksPerSecond - 1'b1);

	assign timeTens = timeLeft[7:4];
	assign timeOnes = timeLeft[3:0];

	// BCD countdown that parks at 00
	always_ff @(posedge clock)
	begin
		if (reset)
			timeLeft <= gameSecondsBcd;
		else if (secondTick && !gameOver)
		begin
			// Borrow from the tens digit
			if (timeOnes == 4'd0)
				timeLeft <= {timeTens - 4'd1, 4'd9};
			else
				timeLeft <= {timeTens, timeOnes - 4'd1};
		end
	end

	assign gameOver = (timeLeft == 8'h00);

endmodule

//--- design/scoreCounter.sv
`timescale 1ns/100ps

module scoreCounter
(
	input  logic clock,
	input  logic reset,
	input  logic hit,
	input  logic wrong,
	output gamePkg::bcdScore score
);

	import gamePkg::*;

	bcdScore incScore;
	bcdScore decScore;
	bcdDigit digit;
	logic carry;
	logic borrow;

	// Ripple BCD increment and decrement through all four digits
	always_comb
	begin
		incScore = score;
		decScore = score;
		carry = 1'b1;
		borrow = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			digit = score[4*i +: 4];
			// Up count, 9 wraps to 0 and passes the carry on
			if (carry)
			begin
				incScore[4*i +: 4] = (digit == 4'd9) ? 4'd0 : digit + 4'd1;
				carry = (digit == 4'd9);
			end
			// Down count, 0 wraps to 9 and passes the borrow on
			if (borrow)
			begin
				decScore[4*i +: 4] = (digit == 4'd0) ? 4'd9 : digit - 4'd1;
				borrow = (digit == 4'd0);
			end
		end
	end

	// Score register
	// Saturates at 9999 going up and 0000 going down
	always_ff @(posedge clock)
	begin
		if (reset)
			score <= '0;
		else if (hit && score != 16'h9999)
			score <= incScore;
		else if (wrong && score != 16'h0000)
			score <= decScore;
	end

endmodule

//--- design/moleLocator.sv
`timescale 1ns/100ps

module moleLocator
(
	input  logic clock,
	input  logic reset,
	input  logic step,
	input  logic holdActive,
	input  gamePkg::keyVector keys,
	output logic hit,
	output logic wrong,
	output logic keysIdle,
	output gamePkg::keyVector moleLeds
);

	import gamePkg::*;
	import timingPkg::*;

	logic [7:0] lfsr;
	logic [7:0] lfsrNext;
	moleIndex position;
	keyVector target;

	// Shift with XOR feedback from fixed taps
	assign lfsrNext = {lfsr[6], lfsr[4] ^ lfsr[2], lfsr[4], lfsr[3] ^ lfsr[1],
		lfsr[2] ^ lfsr[7], lfsr[1], lfsr[0] ^ lfsr[4], lfsr[7] ^ lfsr[6]};

	always_ff @(posedge clock)
	begin
		if (reset)
			lfsr <= lfsrSeed;
		else if (step)
			lfsr <= lfsrNext;
	end

	// Position takes the bits from before the shift
	always_ff @(posedge clock)
	begin
		if (step)
			position <= lfsr[3:2];
	end

	// One-hot mask of the hole in play
	assign target = keyVector'(4'b0001 << position);

	// LED only while the mole is up
	assign moleLeds = holdActive ? target : '0;

	// Any stray key counts against the player first
	assign wrong = holdActive && |(keys & ~target);
	assign hit = holdActive && !wrong && |(keys & target);

	// All keys released
	assign keysIdle = (keys == '0);

endmodule

//--- design/whackGame.sv
`timescale 1ns/100ps

module whackGame
#(
	parameter timingPkg::tickCount ticksPerSecond = 16'd64
)
(
	input  logic clock,
	input  logic reset,
	input  gamePkg::keyVector keys,
	output gamePkg::keyVector moleLeds,
	output gamePkg::segPattern timeTensSeg,
	output gamePkg::segPattern timeOnesSeg,
	output gamePkg::segPattern scoreSeg3,
	output gamePkg::segPattern scoreSeg2,
	output gamePkg::segPattern scoreSeg1,
	output gamePkg::segPattern scoreSeg0
);

	import gamePkg::*;

	logic step;
	logic holdActive;
	logic hit;
	logic wrong;
	logic expired;
	logic keysIdle;
	logic gameOver;
	bcdScore score;
	bcdTime timeLeft;

	// Round sequencing
	gameControl i_gameControl (.clock, .reset, .gameOver, .hit, .wrong, .expired,
		.keysIdle, .step, .holdActive);

	// Window shrinks as the score climbs
	holdTimer #(.ticksPerSecond(ticksPerSecond)) i_holdTimer (.clock, .reset,
		.holdActive, .score, .expired);

	gameClock #(.ticksPerSecond(ticksPerSecond)) i_gameClock (.clock, .reset,
		.timeLeft, .gameOver);

	scoreCounter i_scoreCounter (.clock, .reset, .hit, .wrong, .score);

	moleLocator i_moleLocator (.clock, .reset, .step, .holdActive, .keys, .hit,
		.wrong, .keysIdle, .moleLeds);

	// Display digits
	segmentDecoder i_timeTens (.digit(timeLeft[7:4]), .segments(timeTensSeg));
	segmentDecoder i_timeOnes (.digit(timeLeft[3:0]), .segments(timeOnesSeg));
	segmentDecoder i_score3 (.digit(score[15:12]), .segments(scoreSeg3));
	segmentDecoder i_score2 (.digit(score[11:8]), .segments(scoreSeg2));
	segmentDecoder i_score1 (.digit(score[7:4]), .segments(scoreSeg1));
	segmentDecoder i_score0 (.digit(score[3:0]), .segments(scoreSeg0));

endmodule

//--- tb/whackGame_checker.sv
`timescale 1ns/100ps

module whackGame_checker
(
	input logic clock,
	input logic reset,
	input logic hit,
	input logic wrong,
	input logic gameOver,
	input gamePkg::keyVector moleLeds,
	input gamePkg::bcdScore score
);

	int hitWrongFails = 0;
	int oneHotFails = 0;
	int overFails = 0;
	int digitFails = 0;

	// Judge gives one verdict per round
	assert property (@(posedge clock) disable iff (reset) !(hit && wrong))
		else
		begin
			hitWrongFails++;
			$error("hit and wrong high together");
		end

	assert property (@(posedge clock) disable iff (reset) $onehot0(moleLeds))
		else
		begin
			oneHotFails++;
			$error("moleLeds has more than one bit set");
		end

	// Control reaches the over state one edge after the countdown ends
	assert property (@(posedge clock) disable iff (reset) gameOver |=> (moleLeds == '0))
		else
		begin
			overFails++;
			$error("moleLeds lit after game over");
		end

	assert property (@(posedge clock) disable iff (reset) (score[15:12] <= 4'd9) &&
		(score[11:8] <= 4'd9) && (score[7:4] <= 4'd9) && (score[3:0] <= 4'd9))
		else
		begin
			digitFails++;
			$error("score digit above 9");
		end

endmodule

bind whackGame whackGame_checker i_checker (.clock(clock), .reset(reset), .hit(hit),
	.wrong(wrong), .gameOver(gameOver), .moleLeds(moleLeds), .score(score));

//--- tb/whackGame_tb.sv
`timescale 1ns/100ps

module whackGame_tb;

	import gamePkg::*;
	import timingPkg::*;

	localparam int ticksPerSecond = 64;
	localparam int resetCycles = 16;
	localparam int rounds = 36;
	localparam int gameCycles = 45 * ticksPerSecond;
	// Whole game plus margin for reset and the closing checks
	localparam int timeoutCycles = 50 * ticksPerSecond;

	logic clock;
	logic reset;
	keyVector keys;
	keyVector moleLeds;
	segPattern timeTensSeg;
	segPattern timeOnesSeg;
	segPattern scoreSeg3;
	segPattern scoreSeg2;
	segPattern scoreSeg1;
	segPattern scoreSeg0;

	logic [23:0] golden [0:rounds-1];
	int cycleCount = 0;
	int valueErrors = 0;
	int assertErrors = 0;

	whackGame #(.ticksPerSecond(tickCount'(ticksPerSecond))) i_whackGame (.clock, .reset,
		.keys, .moleLeds, .timeTensSeg, .timeOnesSeg, .scoreSeg3, .scoreSeg2, .scoreSeg1,
		.scoreSeg0);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Watchdog on total run length
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutCycles)
		begin
			$display("Timeout after %0d cycles without reaching the end of the test", cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	// Active-low pattern back to a digit
	function automatic int segDigit(input segPattern pattern);
		case (pattern)
			7'b1000000: return 0;
			7'b1111001: return 1;
			7'b0100100: return 2;
			7'b0110000: return 3;
			7'b0011001: return 4;
			7'b0010010: return 5;
			7'b0000010: return 6;
			7'b1111000: return 7;
			7'b0000000: return 8;
			7'b0010000: return 9;
			// Blank or garbage lands out of range
			default: return 10000;
		endcase
	endfunction

	function automatic int shownScore();
		return 1000 * segDigit(scoreSeg3) + 100 * segDigit(scoreSeg2) +
			10 * segDigit(scoreSeg1) + segDigit(scoreSeg0);
	endfunction

	function automatic int shownTime();
		return 10 * segDigit(timeTensSeg) + segDigit(timeOnesSeg);
	endfunction

	function automatic int bcdValue(input logic [15:0] bcd);
		return 1000 * int'(bcd[15:12]) + 100 * int'(bcd[11:8]) + 10 * int'(bcd[7:4]) +
			int'(bcd[3:0]);
	endfunction

	task automatic reportMismatch(input string name, input int expected, input int actual);
		valueErrors++;
		$display("Fail at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
	endtask

	initial
	begin
		logic [3:0] action;
		moleIndex position;
		int expScore;
		int prevScore;
		int windowCycles;
		int litCycles;
		keys <= '0;
		reset <= 1'b1;
		$readmemh("tb/whackGame_golden.txt", golden);
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		if (shownTime() != 45)
			reportMismatch("time", 45, shownTime());
		if (shownScore() != 0)
			reportMismatch("score", 0, shownScore());
		if (moleLeds != '0)
			reportMismatch("moleLeds", 0, int'(moleLeds));
		prevScore = 0;
		for (int idx = 0; idx < rounds; idx++)
		begin
			action = golden[idx][23:20];
			position = golden[idx][17:16];
			expScore = bcdValue(golden[idx][15:0]);
			// Window tier follows the score going into the round
			windowCycles = (prevScore >= 30) ? ticksPerSecond / 4 :
				(prevScore >= 15) ? ticksPerSecond / 2 : ticksPerSecond;
			while (moleLeds == '0)
				@(negedge clock);
			if (int'(moleLeds) != (1 << position))
				reportMismatch("moleLeds", 1 << position, int'(moleLeds));
			if (action == 4'd0)
			begin
				// Count cycles with the LED lit, first one already seen
				litCycles = 1;
				@(negedge clock);
				while (moleLeds != '0)
				begin
					litCycles++;
					@(negedge clock);
				end
				if (litCycles != windowCycles)
					reportMismatch("hold window", windowCycles, litCycles);
			end
			else
			begin
				@(posedge clock);
				if (action == 4'd1)
					keys <= keyVector'(4'b0001 << position);
				else
					keys <= keyVector'(4'b0001 << moleIndex'(position + 2'd1));
				@(posedge clock);
				keys <= '0;
				@(negedge clock);
			end
			if (shownScore() != expScore)
				reportMismatch("score", expScore, shownScore());
			prevScore = expScore;
		end
		// Let the countdown run out
		while (shownTime() != 0)
			@(negedge clock);
		if (cycleCount - resetCycles != gameCycles)
			reportMismatch("game length", gameCycles, cycleCount - resetCycles);
		@(posedge clock);
		keys <= 4'b1111;
		repeat (8)
		begin
			@(negedge clock);
			if (moleLeds != '0)
				reportMismatch("moleLeds", 0, int'(moleLeds));
			if (shownScore() != prevScore)
				reportMismatch("score", prevScore, shownScore());
			if (shownTime() != 0)
				reportMismatch("time", 0, shownTime());
		end
		assertErrors = i_whackGame.i_checker.hitWrongFails + i_whackGame.i_checker.oneHotFails +
			i_whackGame.i_checker.overFails + i_whackGame.i_checker.digitFails;
		$display("Errors: %0d value mismatches, %0d assertion failures", valueErrors,
			assertErrors);
		if (valueErrors == 0 && assertErrors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tb/whackGame_golden.txt
// Each hex word is one round with its action, LED position and BCD score after it
// Action 0 is no key, 1 the lit key, 2 the key after the lit one
// Wrong key at zero and an idle window below 15
200000 000000
// Ten hits through the carry from 9 to 10, then a wrong key
110001 120002 110003 120004 100005 120006
100007 130008 120009 120010 200009
// Hits up to 15 and an idle window in the middle tier
120010 120011 120012 110013 100014 130015 000015
// Hits up to 30 and an idle window in the top tier
110016 120017 130018 130019 130020 100021 130022 110023
110024 120025 120026 110027 120028 120029 130030 030030

//--- vlog.f
design/gamePkg.sv
design/timingPkg.sv
design/segmentDecoder.sv
design/gameControl.sv
design/holdTimer.sv
design/gameClock.sv
design/scoreCounter.sv
design/moleLocator.sv
design/whackGame.sv
tb/whackGame_checker.sv
tb/whackGame_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the whackGame testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
	--top-module whackGame_tb; then
	echo "Verilator build failed"
	exit 1
fi

if ! simOutput=$(./obj_dir/VwhackGame_tb +verilator+error+limit+1000); then
	echo "$simOutput"
	echo "Simulation exited with an error status"
	exit 1
fi
echo "$simOutput"

if echo "$simOutput" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
